// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
if ! verilator --binary --timing --assert -f src.f --top-module l2_write_tb \
        -Mdir obj_dir -o l2_write_sim > build.log 2>&1; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/l2_write_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test completed successfully" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: src.f
src/l2w_pkg.sv
src/write_buffer.sv
src/write_arbiter.sv
src/l2_write_top.sv
test/mem_slave_model.sv
test/l2_write_props.sv
test/l2_write_tb.sv

// File: src/l2_write_top.sv
`timescale 1ns/1ns

module l2_write_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [31:0]                   req_addr,
    input  logic [l2w_pkg::LINE_BITS-1:0] req_data,
    input  logic [3:0]                    req_wstrb,
    input  logic                          req_uncached,
    input  logic                          req_valid,
    output logic                          req_ready,
    output logic [31:0]                   aw_addr,
    output logic [7:0]                    aw_len,
    output logic                          aw_valid,
    input  logic                          aw_ready,
    output logic [31:0]                   w_data,
    output logic [3:0]                    w_strb,
    output logic                          w_valid,
    output logic                          w_last,
    input  logic                          w_ready,
    input  logic                          b_valid,
    output logic                          b_ready
);
    import l2w_pkg::*;

    // arbiter to buffer
    logic [31:0]          wb_addr;
    logic [LINE_BITS-1:0] wb_data;
    logic                 wb_valid;
    logic                 wb_ready;
    logic                 wb_busy;

    // buffer bus side
    logic [31:0]          wb_aw_addr;
    logic                 wb_aw_valid;
    logic                 wb_aw_ready;
    logic [31:0]          wb_w_data;
    logic                 wb_w_valid;
    logic                 wb_w_last;
    logic                 wb_w_ready;
    logic                 wb_b_valid;
    logic                 wb_b_ready;

    write_arbiter arb_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_addr     (req_addr),
        .req_data     (req_data),
        .req_wstrb    (req_wstrb),
        .req_uncached (req_uncached),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .wb_valid     (wb_valid),
        .wb_ready     (wb_ready),
        .wb_busy      (wb_busy),
        .wb_aw_addr   (wb_aw_addr),
        .wb_aw_valid  (wb_aw_valid),
        .wb_aw_ready  (wb_aw_ready),
        .wb_w_data    (wb_w_data),
        .wb_w_valid   (wb_w_valid),
        .wb_w_last    (wb_w_last),
        .wb_w_ready   (wb_w_ready),
        .wb_b_valid   (wb_b_valid),
        .wb_b_ready   (wb_b_ready),
        .aw_addr      (aw_addr),
        .aw_len       (aw_len),
        .aw_valid     (aw_valid),
        .aw_ready     (aw_ready),
        .w_data       (w_data),
        .w_strb       (w_strb),
        .w_valid      (w_valid),
        .w_last       (w_last),
        .w_ready      (w_ready),
        .b_valid      (b_valid),
        .b_ready      (b_ready)
    );

    write_buffer wbuf_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .wb_busy     (wb_busy),
        .wb_aw_addr  (wb_aw_addr),
        .wb_aw_valid (wb_aw_valid),
        .wb_aw_ready (wb_aw_ready),
        .wb_w_data   (wb_w_data),
        .wb_w_valid  (wb_w_valid),
        .wb_w_last   (wb_w_last),
        .wb_w_ready  (wb_w_ready),
        .wb_b_valid  (wb_b_valid),
        .wb_b_ready  (wb_b_ready)
    );

endmodule

// File: src/l2w_pkg.sv
package l2w_pkg;

    // line geometry
    localparam int OFFSET_WIDTH = 2;                // word offset bits in a line
    localparam int LINE_WORDS   = 1 << OFFSET_WIDTH;
    localparam int LINE_BITS    = LINE_WORDS * 32;

    // burst length field of a full line drain
    localparam logic [7:0] BURST_LEN = 8'(LINE_WORDS - 1);

    // write buffer sizing, depth is a power of two
    localparam int WB_DEPTH = 2;
    localparam int WB_PTR_W = 1;

endpackage

// File: src/write_arbiter.sv
`timescale 1ns/1ns

module write_arbiter (
    input  logic                          clk,
    input  logic                          rst_n,
    // cache request
    input  logic [31:0]                   req_addr,
    input  logic [l2w_pkg::LINE_BITS-1:0] req_data,
    input  logic [3:0]                    req_wstrb,
    input  logic                          req_uncached,
    input  logic                          req_valid,
    output logic                          req_ready,
    // buffer entry
    output logic [31:0]                   wb_addr,
    output logic [l2w_pkg::LINE_BITS-1:0] wb_data,
    output logic                          wb_valid,
    input  logic                          wb_ready,
    input  logic                          wb_busy,
    // buffer bus side
    input  logic [31:0]                   wb_aw_addr,
    input  logic                          wb_aw_valid,
    output logic                          wb_aw_ready,
    input  logic [31:0]                   wb_w_data,
    input  logic                          wb_w_valid,
    input  logic                          wb_w_last,
    output logic                          wb_w_ready,
    output logic                          wb_b_valid,
    input  logic                          wb_b_ready,
    // shared write channel
    output logic [31:0]                   aw_addr,
    output logic [7:0]                    aw_len,
    output logic                          aw_valid,
    input  logic                          aw_ready,
    output logic [31:0]                   w_data,
    output logic [3:0]                    w_strb,
    output logic                          w_valid,
    output logic                          w_last,
    input  logic                          w_ready,
    input  logic                          b_valid,
    output logic                          b_ready
);
    import l2w_pkg::*;

    localparam logic [1:0] IDLE  = 2'd0;
    localparam logic [1:0] UC_AW = 2'd1;
    localparam logic [1:0] UC_W  = 2'd2;
    localparam logic [1:0] UC_B  = 2'd3;

    logic [1:0] state;
    logic [1:0] state_nxt;
    logic       cached_req;

    assign cached_req = req_valid && !req_uncached;

    // uncached writes wait for the buffer to drain, keeping request order
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req_valid && req_uncached && !wb_busy) begin
                    state_nxt = UC_AW;
                end
            end
            UC_AW: begin
                if (aw_ready) begin
                    state_nxt = UC_W;
                end
            end
            UC_W: begin
                if (w_ready) begin
                    state_nxt = UC_B;
                end
            end
            UC_B: begin
                if (b_valid) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // buffer entry path, request fields go straight through
    assign wb_addr  = req_addr;
    assign wb_data  = req_data;
    assign wb_valid = (state == IDLE) && cached_req;

    always_comb begin
        req_ready   = 1'b0;
        aw_addr     = '0;
        aw_len      = '0;
        aw_valid    = 1'b0;
        w_data      = '0;
        w_strb      = '0;
        w_valid     = 1'b0;
        w_last      = 1'b0;
        b_ready     = 1'b0;
        wb_aw_ready = 1'b0;
        wb_w_ready  = 1'b0;
        wb_b_valid  = 1'b0;
        case (state)
            IDLE: begin
                req_ready   = cached_req && wb_ready;
                // buffer owns the channel
                aw_addr     = wb_aw_addr;
                aw_len      = BURST_LEN;
                aw_valid    = wb_aw_valid;
                w_data      = wb_w_data;
                w_strb      = 4'hf;
                w_valid     = wb_w_valid;
                w_last      = wb_w_last;
                b_ready     = wb_b_ready;
                wb_aw_ready = aw_ready;
                wb_w_ready  = w_ready;
                wb_b_valid  = b_valid;
            end
            UC_AW: begin
                aw_addr  = req_addr;
                aw_valid = 1'b1;
                w_strb   = req_wstrb;
            end
            UC_W: begin
                w_data  = req_data[31:0];   // single low word
                w_strb  = req_wstrb;
                w_valid = 1'b1;
                w_last  = 1'b1;
            end
            UC_B: begin
                w_strb    = req_wstrb;
                b_ready   = 1'b1;
                req_ready = b_valid;        // request ends on the response
            end
            default: ;
        endcase
    end

endmodule

// File: src/write_buffer.sv
`timescale 1ns/1ns

module write_buffer (
    input  logic                          clk,
    input  logic                          rst_n,
    // entry side
    input  logic [31:0]                   wb_addr,
    input  logic [l2w_pkg::LINE_BITS-1:0] wb_data,
    input  logic                          wb_valid,
    output logic                          wb_ready,
    output logic                          wb_busy,
    // bus side
    output logic [31:0]                   wb_aw_addr,
    output logic                          wb_aw_valid,
    input  logic                          wb_aw_ready,
    output logic [31:0]                   wb_w_data,
    output logic                          wb_w_valid,
    output logic                          wb_w_last,
    input  logic                          wb_w_ready,
    input  logic                          wb_b_valid,
    output logic                          wb_b_ready
);
    import l2w_pkg::*;

    localparam logic [1:0] D_IDLE = 2'd0;
    localparam logic [1:0] D_AW   = 2'd1;
    localparam logic [1:0] D_W    = 2'd2;
    localparam logic [1:0] D_B    = 2'd3;

    logic [31:0]             addr_q [WB_DEPTH];
    logic [LINE_BITS-1:0]    line_q [WB_DEPTH];
    logic [WB_PTR_W-1:0]     head;
    logic [WB_PTR_W-1:0]     tail;
    logic [WB_PTR_W:0]       count;
    logic [1:0]              state;
    logic [1:0]              state_nxt;
    logic [OFFSET_WIDTH-1:0] beat;
    logic                    last_beat;
    logic                    push;
    logic                    pop;
    logic [LINE_BITS-1:0]    head_line;

    assign push = wb_valid && wb_ready;
    assign pop  = (state == D_B) && wb_b_valid;     // entry frees on the response

    assign wb_ready = (count != (WB_PTR_W + 1)'(WB_DEPTH));
    assign wb_busy  = (count != '0) || (state != D_IDLE);

    // line storage, written at the tail
    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[tail] <= {wb_addr[31:OFFSET_WIDTH+2], {(OFFSET_WIDTH + 2){1'b0}}};
            line_q[tail] <= wb_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // drain FSM for the head entry
    assign last_beat = (beat == OFFSET_WIDTH'(LINE_WORDS - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            D_IDLE: begin
                if (count != '0) begin
                    state_nxt = D_AW;
                end
            end
            D_AW: begin
                if (wb_aw_ready) begin
                    state_nxt = D_W;
                end
            end
            D_W: begin
                if (wb_w_ready && last_beat) begin
                    state_nxt = D_B;
                end
            end
            D_B: begin
                if (wb_b_valid) begin
                    state_nxt = D_IDLE;
                end
            end
            default: state_nxt = D_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= D_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // wraps back to zero after the last beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat <= '0;
        end else if ((state == D_W) && wb_w_ready) begin
            beat <= beat + 1'b1;
        end
    end

    assign head_line = line_q[head];

    assign wb_aw_addr  = addr_q[head];
    assign wb_aw_valid = (state == D_AW);
    assign wb_w_data   = head_line[beat*32 +: 32];  // word 0 sits in the low bits
    assign wb_w_valid  = (state == D_W);
    assign wb_w_last   = (state == D_W) && last_beat;
    assign wb_b_ready  = (state == D_B);

endmodule

// File: test/l2_write_props.sv
`timescale 1ns/1ns

module l2_write_props (
    input logic        clk,
    input logic        rst_n,
    input logic        req_ready,
    input logic [31:0] aw_addr,
    input logic [7:0]  aw_len,
    input logic        aw_valid,
    input logic        aw_ready,
    input logic [31:0] w_data,
    input logic        w_valid,
    input logic        w_last,
    input logic        w_ready,
    input logic        b_ready,
    input logic        wb_busy
);
    logic [7:0] beat_cnt;
    logic [7:0] burst_len;              // aw_len of the burst in flight

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt  <= '0;
            burst_len <= '0;
        end else begin
            if (aw_valid && aw_ready) begin
                burst_len <= aw_len;
            end
            if (w_valid && w_ready) begin
                beat_cnt <= w_last ? 8'd0 : beat_cnt + 1'b1;
            end
        end
    end

    // quiet channel while in reset
    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !req_ready && !aw_valid && !w_valid && !w_last && !b_ready)
        else $error("channel outputs active during reset");

    // w_last only on the beat numbered by the transferred aw_len
    last_on_final_beat: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid && w_ready |-> (w_last == (beat_cnt == burst_len)))
        else $error("w_last does not match the burst length");

    uncached_after_drain: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid && (aw_len == 8'd0) |-> !wb_busy)
        else $error("uncached address issued while the buffer is busy");

    aw_held: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr) && $stable(aw_len))
        else $error("address phase dropped or changed before transfer");

    w_held: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_last))
        else $error("data beat dropped or changed before transfer");

endmodule

// File: test/l2_write_tb.sv
`timescale 1ns/1ns

bind write_arbiter l2_write_props props_i (.*);

module l2_write_tb;
    import l2w_pkg::*;

    localparam int MEM_WORDS  = 256;
    localparam int NUM_REQ    = 10;
    localparam int REQ_NS     = 400;    // a line drain with 3-cycle stalls on every phase
    localparam int TIMEOUT_NS = NUM_REQ * REQ_NS + (8 + 10) * 10;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic [31:0]          req_addr;
    logic [LINE_BITS-1:0] req_data;
    logic [3:0]           req_wstrb;
    logic                 req_uncached;
    logic                 req_valid;
    logic                 req_ready;
    logic [31:0]          aw_addr;
    logic [7:0]           aw_len;
    logic                 aw_valid;
    logic                 aw_ready;
    logic [31:0]          w_data;
    logic [3:0]           w_strb;
    logic                 w_valid;
    logic                 w_last;
    logic                 w_ready;
    logic                 b_valid;
    logic                 b_ready;
    logic                 hold_aw;

    logic [31:0] exp_mem [MEM_WORDS];
    int          accepted = 0;
    bit          done_ok;
    bit          fail_shown;

    always #5 clk = ~clk;

    l2_write_top dut_i (.*);

    mem_slave_model #(.MEM_WORDS(MEM_WORDS)) mem_i (.*);

    // request handshakes seen at the DUT boundary
    always @(posedge clk) begin
        if (rst_n && req_valid && req_ready) begin
            accepted <= accepted + 1;
        end
    end

    task automatic present_request(input logic [31:0] addr, input logic [LINE_BITS-1:0] data,
                                   input logic [3:0] strb, input logic unc);
        @(posedge clk);
        #1;
        req_addr     = addr;
        req_data     = data;
        req_wstrb    = strb;
        req_uncached = unc;
        req_valid    = 1'b1;
    endtask

    // req_ready is settled by the falling edge
    task automatic wait_accept();
        do @(negedge clk); while (!req_ready);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic write_line(input logic [31:0] addr, input logic [LINE_BITS-1:0] data);
        int base;
        present_request(addr, data, 4'hf, 1'b0);
        wait_accept();
        base = int'(addr[9:4]) * LINE_WORDS;
        for (int k = 0; k < LINE_WORDS; k++) begin
            exp_mem[base + k] = data[32*k +: 32];
        end
    endtask

    task automatic write_uncached(input logic [31:0] addr, input logic [31:0] word,
                                  input logic [3:0] strb);
        int idx;
        present_request(addr, {96'h0, word}, strb, 1'b1);
        wait_accept();
        idx = int'(addr[9:2]);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) exp_mem[idx][8*b +: 8] = word[8*b +: 8];
        end
    endtask

    task automatic wait_drained();
        do @(negedge clk); while (dut_i.wb_busy || aw_valid || w_valid || b_ready);
    endtask

    task automatic compare_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (mem_i.mem[i] !== exp_mem[i]) begin
                $display("ERROR t=%0t mem[%0d] expected %h actual %h",
                         $time, i, exp_mem[i], mem_i.mem[i]);
                $display("Test failed");
                fail_shown = 1'b1;
                $fatal(1, "memory mismatch");
            end
        end
    endtask

    initial begin
        void'($urandom(5));
        rst_n        = 1'b0;
        req_addr     = '0;
        req_data     = '0;
        req_wstrb    = '0;
        req_uncached = 1'b0;
        req_valid    = 1'b0;
        hold_aw      = 1'b0;
        done_ok      = 1'b0;
        fail_shown   = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) exp_mem[i] = mem_i.mem[i];

        // single cached line
        write_line(32'h0000_0024, 128'h0403_0201_1413_1211_2423_2221_3433_3231);
        wait_drained();
        compare_memory();

        // partial uncached word
        write_uncached(32'h0000_0084, 32'hdead_beef, 4'b1001);
        compare_memory();

        // two lines then an uncached write into the first one
        write_line(32'h0000_0100, 128'haaaa_0003_aaaa_0002_aaaa_0001_aaaa_0000);
        write_line(32'h0000_0140, 128'hbbbb_0003_bbbb_0002_bbbb_0001_bbbb_0000);
        write_uncached(32'h0000_0108, 32'h1122_3344, 4'b0110);
        wait_drained();
        compare_memory();

        // random lines under random slave delays
        repeat (2) begin
            write_line(32'h200 | ($urandom & 32'h1f0),
                       {$urandom, $urandom, $urandom, $urandom});
        end
        wait_drained();
        compare_memory();

        // full buffer back-pressure
        @(posedge clk);
        #1;
        hold_aw = 1'b1;
        write_line(32'h0000_0040, 128'hc0c0_0003_c0c0_0002_c0c0_0001_c0c0_0000);
        write_line(32'h0000_0060, 128'hd0d0_0003_d0d0_0002_d0d0_0001_d0d0_0000);
        present_request(32'h0000_00c0, 128'he0e0_0003_e0e0_0002_e0e0_0001_e0e0_0000,
                        4'hf, 1'b0);
        repeat (10) begin
            @(negedge clk);
            if (req_ready) begin
                $display("third cached request accepted while both entries were full");
                $display("Test failed");
                fail_shown = 1'b1;
                $fatal(1, "no back-pressure");
            end
        end
        @(posedge clk);
        #1;
        hold_aw = 1'b0;
        wait_accept();
        for (int k = 0; k < LINE_WORDS; k++) exp_mem[48 + k] = req_data[32*k +: 32];
        wait_drained();
        compare_memory();

        if (accepted == NUM_REQ) begin
            done_ok = 1'b1;
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("only %0d of %0d requests were accepted", accepted, NUM_REQ);
            $display("Test failed");
            fail_shown = 1'b1;
            $fatal(1, "handshake count");
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before all requests finished");
        $display("Test failed");
        fail_shown = 1'b1;
        $fatal(1, "timeout");
    end

    // reached when an assertion stops the run
    final begin
        if (!done_ok && !fail_shown) begin
            $display("Test failed");
        end
    end

endmodule

// File: test/mem_slave_model.sv
`timescale 1ns/1ns

module mem_slave_model #(
    parameter int MEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        hold_aw,         // stalls the address phase while high
    input  logic [31:0] aw_addr,
    input  logic [7:0]  aw_len,
    input  logic        aw_valid,
    output logic        aw_ready,
    input  logic [31:0] w_data,
    input  logic [3:0]  w_strb,
    input  logic        w_valid,
    input  logic        w_last,
    output logic        w_ready,
    output logic        b_valid,
    input  logic        b_ready
);
    localparam int IDX_W = $clog2(MEM_WORDS);

    localparam logic [1:0] S_AW = 2'd0;
    localparam logic [1:0] S_W  = 2'd1;
    localparam logic [1:0] S_B  = 2'd2;

    logic [31:0]      mem [MEM_WORDS];
    logic [1:0]       state;
    logic [1:0]       dly;
    logic [IDX_W-1:0] wr_idx;
    logic [7:0]       beats;             // beats seen in the current burst

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
        end
    end

    // byte strobes applied per lane
    always @(posedge clk) begin
        if ((state == S_W) && w_valid && w_ready) begin
            for (int b = 0; b < 4; b++) begin
                if (w_strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= w_data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_AW;
            dly      <= '0;
            wr_idx   <= '0;
            beats    <= '0;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
        end else begin
            case (state)
                S_AW: begin
                    if (aw_valid && aw_ready) begin
                        aw_ready <= 1'b0;
                        wr_idx   <= aw_addr[IDX_W+1:2];
                        beats    <= '0;
                        dly      <= 2'($urandom_range(0, 3));
                        state    <= S_W;
                    end else if (aw_valid && !hold_aw) begin
                        if (dly == '0) aw_ready <= 1'b1;
                        else dly <= dly - 1'b1;
                    end
                end
                S_W: begin
                    if (w_valid && w_ready) begin
                        w_ready <= 1'b0;
                        wr_idx  <= wr_idx + 1'b1;
                        beats   <= beats + 1'b1;
                        dly     <= 2'($urandom_range(0, 3));
                        if (w_last || (beats == aw_len)) begin
                            state <= S_B;
                        end
                    end else if (w_valid) begin
                        if (dly == '0) w_ready <= 1'b1;
                        else dly <= dly - 1'b1;
                    end
                end
                default: begin
                    if (b_valid && b_ready) begin
                        b_valid <= 1'b0;
                        dly     <= 2'($urandom_range(0, 3));
                        state   <= S_AW;
                    end else if (dly == '0) begin
                        b_valid <= 1'b1;
                    end else begin
                        dly <= dly - 1'b1;
                    end
                end
            endcase
        end
    end

endmodule
